// File: logic/cart_pkg.sv
// Shared types, enums and memory map constants for the cartridge loader; import into each module
`default_nettype none

package cart_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus widths
	typedef logic [15:0] word_t;      // Download and memory data
	typedef logic [24:0] load_addr_t; // Download byte address
	typedef logic [22:0] cpu_addr_t;  // CPU word address, byte bits 23..1
	typedef logic [23:0] mem_addr_t;  // Memory word address
	typedef logic [4:0]  bank_t;      // One bank per 512 KB window
	typedef logic [10:0] rom_mask_t;  // Byte address bits 23..13
	typedef logic [2:0]  page_sel_t;  // Page register select

	// Region encoding follows the console export/PAL bits
	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	typedef enum logic [1:0] {
		AUTO     = 2'd0,
		FORCE_JP = 2'd1,
		FORCE_US = 2'd2,
		FORCE_EU = 2'd3
	} region_ovr_t;

	////////////////////////////////////////////////////////////////////////////
	// Loader index decode
	localparam int             LOAD_INDEX_TYPE_BITS = 6;     // Low index bits give the file type
	localparam logic [5:0]     LOAD_INDEX_ROM_MAX   = 6'h01; // Types 0 and 1 are ROM images
	localparam int             LOAD_INDEX_CART_BIT  = 6;     // Set for cartridge, clear for BIOS

	// Cartridge header
	localparam load_addr_t     HEADER_REGION_ADDR   = 25'h1F0;
	localparam logic [7:0]     HEADER_CHAR_JP       = 8'h4A; // 'J'
	localparam logic [7:0]     HEADER_CHAR_US       = 8'h55; // 'U'

	// Mapper geometry
	localparam int             ROM_MASK_LSB         = 13; // Mask granularity is 8 KB
	localparam int             BANK_WINDOW_W        = 18; // Word bits inside a 512 KB window
	localparam int             NUM_BANKS            = 8;

	// Memory map, in words
	localparam mem_addr_t      CART_ROM_BASE        = 24'h000000;
	localparam mem_addr_t      BIOS_BASE            = 24'h780000;

endpackage

`default_nettype wire

// File: logic/cart_load_tracker.sv
// Download input stage: qualifies ROM words and tracks cartridge mode, size mask and header region
`timescale 1ns/1ps
`default_nettype none

module cart_load_tracker (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       load_active,
	input  wire [7:0]                 load_index,
	input  wire                       load_wr,
	input  wire cart_pkg::load_addr_t load_addr,
	input  wire cart_pkg::word_t      load_data,
	output logic                      rom_active,
	output logic                      cart_mode,
	output cart_pkg::rom_mask_t       rom_mask,
	output cart_pkg::region_t         header_region
);
	import cart_pkg::*;

	logic       rom_wr;
	logic       index_cart;
	logic       cart_mode_q;
	logic [7:0] header_char;

	////////////////////////////////////////////////////////////////////////////
	// Index decode
	assign rom_active  = load_active &&
		(load_index[LOAD_INDEX_TYPE_BITS-1:0] <= LOAD_INDEX_ROM_MAX);
	assign index_cart  = load_index[LOAD_INDEX_CART_BIT];
	assign rom_wr      = rom_active && load_wr;
	assign header_char = load_data[7:0]; // Letter sits in the low byte

	// During a load the mode comes straight from the index, so the very
	// first word of a new image already lands in the right memory area
	assign cart_mode = rom_active ? index_cart : cart_mode_q;

	////////////////////////////////////////////////////////////////////////////
	// Mode, size mask and region letter
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_mode_q   <= 1'b0;
			rom_mask      <= '0;
			header_region <= JP;
		end else if (rom_wr) begin
			cart_mode_q <= index_cart;

			// Mask grows with the highest address seen
			if (index_cart) begin
				if (load_addr == '0) begin
					rom_mask <= '0; // New image starts
				end else begin
					rom_mask <= rom_mask | load_addr[23:ROM_MASK_LSB];
				end
			end

			if (load_addr == HEADER_REGION_ADDR) begin
				if (header_char == HEADER_CHAR_JP) begin
					header_region <= JP;
				end else if (header_char == HEADER_CHAR_US) begin
					header_region <= US;
				end else begin
					header_region <= EU; // Any other letter
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/region_select.sv
// Active region choice from header or override, with a settle window after every change
`timescale 1ns/1ps
`default_nettype none

module region_select #(
	parameter int SETTLE_CYCLES = 65535
) (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire cart_pkg::region_t     header_region,
	input  wire cart_pkg::region_ovr_t region_ovr,
	output cart_pkg::region_t          region,
	output logic                       pal,
	output logic                       region_settle
);
	import cart_pkg::*;

	localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

	region_t          region_new;
	logic [CNT_W-1:0] settle_cnt;

	// Forced setting beats the header letter
	always_comb begin
		case (region_ovr)
			FORCE_JP: region_new = JP;
			FORCE_US: region_new = US;
			FORCE_EU: region_new = EU;
			default:  region_new = header_region;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Region register and settle counter
	always_ff @(posedge clk_sys) begin
		region <= region_new; // One cycle behind the selection

		if (reset) begin
			settle_cnt <= CNT_W'(SETTLE_CYCLES);
		end else if (region_new != region) begin
			settle_cnt <= CNT_W'(SETTLE_CYCLES); // Restart window
		end else if (settle_cnt != '0) begin
			settle_cnt <= settle_cnt - 1'b1;
		end
	end

	// Held high so the console reset can pick up the new video standard
	assign region_settle = (settle_cnt != '0);
	assign pal           = (region == EU);

endmodule

`default_nettype wire

// File: logic/bank_mapper.sv
// Large-ROM mapper: eight bank registers behind the page window and CPU address translation
`timescale 1ns/1ps
`default_nettype none

module bank_mapper (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire                      rom_active,
	input  wire cart_pkg::rom_mask_t rom_mask,
	input  wire                      page_wr,
	input  wire cart_pkg::page_sel_t page_sel,
	input  wire cart_pkg::bank_t     page_data,
	input  wire                      cpu_rd,
	input  wire cart_pkg::cpu_addr_t cpu_addr,
	output logic                     rom_rd_stb,
	output cart_pkg::cpu_addr_t      rom_word_addr
);
	import cart_pkg::*;

	bank_t     bank_reg [NUM_BANKS];
	logic      big_rom;
	logic      bank_we;
	page_sel_t bank_sel;
	cpu_addr_t banked_addr;
	cpu_addr_t rom_addr_mask;

	////////////////////////////////////////////////////////////////////////////
	// Page window writes
	// Only images over 4 MB bank; select 0 is the fixed lower window
	assign big_rom = rom_mask[23-ROM_MASK_LSB] | rom_mask[22-ROM_MASK_LSB];
	assign bank_we = page_wr && big_rom && (page_sel != '0);

	always_ff @(posedge clk_sys) begin
		if (reset || rom_active) begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				bank_reg[i] <= bank_t'(i); // Identity map
			end
		end else if (bank_we) begin
			bank_reg[page_sel] <= page_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Address translation
	assign bank_sel    = cpu_addr[BANK_WINDOW_W+2:BANK_WINDOW_W]; // Byte bits 21..19
	assign banked_addr = {bank_reg[bank_sel], cpu_addr[BANK_WINDOW_W-1:0]};

	// Ones below the mask granularity, so small images mirror
	assign rom_addr_mask = {rom_mask, {(ROM_MASK_LSB - 1){1'b1}}};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_rd_stb <= 1'b0;
		end else begin
			rom_rd_stb <= cpu_rd && !rom_active; // No reads while loading
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_rd) begin
			rom_word_addr <= banked_addr & rom_addr_mask;
		end
	end

endmodule

`default_nettype wire

// File: logic/mem_request.sv
// Memory request merge: registered download writes and mapped CPU reads onto one port
`timescale 1ns/1ps
`default_nettype none

module mem_request (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       rom_active,
	input  wire                       cart_mode,
	input  wire                       load_wr,
	input  wire cart_pkg::load_addr_t load_addr,
	input  wire cart_pkg::word_t      load_data,
	input  wire                       rom_rd_stb,
	input  wire cart_pkg::cpu_addr_t  rom_word_addr,
	output cart_pkg::mem_addr_t       mem_addr,
	output cart_pkg::word_t           mem_wdata,
	output logic                      mem_wr,
	output logic                      mem_rd
);
	import cart_pkg::*;

	logic      load_req;
	mem_addr_t load_mem_addr;
	mem_addr_t wr_addr_q;
	mem_addr_t rd_addr;

	assign load_req = load_wr && rom_active;

	// Cartridge images fill the ROM area, anything else is the BIOS
	always_comb begin
		if (cart_mode) begin
			load_mem_addr = CART_ROM_BASE + mem_addr_t'(load_addr[22:1]);
		end else begin
			load_mem_addr = BIOS_BASE + mem_addr_t'(load_addr[18:1]);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Download write stage
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_wr <= 1'b0;
		end else begin
			mem_wr <= load_req;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (load_req) begin
			wr_addr_q <= load_mem_addr;
			mem_wdata <= {load_data[7:0], load_data[15:8]}; // Loader is byte swapped
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read path, already registered in the mapper
	assign rd_addr  = CART_ROM_BASE + mem_addr_t'(rom_word_addr[21:0]);
	assign mem_rd   = rom_rd_stb;
	assign mem_addr = rom_rd_stb ? rd_addr : wr_addr_q; // Never both, reads blocked in load

endmodule

`default_nettype wire

// File: logic/cart_top.sv
// Cartridge loading and bank mapping top level; connects loader, region, mapper and memory port
`timescale 1ns/1ps
`default_nettype none

module cart_top #(
	parameter int SETTLE_CYCLES = 65535 // Region settle window in clocks
) (
	input  wire                        clk_sys,
	input  wire                        reset,

	// Host download port
	input  wire                        load_active,
	input  wire [7:0]                  load_index,
	input  wire                        load_wr,
	input  wire cart_pkg::load_addr_t  load_addr,
	input  wire cart_pkg::word_t       load_data,

	// Time/page register window
	input  wire                        page_wr,
	input  wire cart_pkg::page_sel_t   page_sel,
	input  wire cart_pkg::bank_t       page_data,

	// CPU ROM reads
	input  wire                        cpu_rd,
	input  wire cart_pkg::cpu_addr_t   cpu_addr,

	// Region
	input  wire cart_pkg::region_ovr_t region_ovr,
	output wire cart_pkg::region_t     region,
	output wire                        pal,
	output wire                        region_settle,

	// Memory request port
	output wire cart_pkg::mem_addr_t   mem_addr,
	output wire cart_pkg::word_t       mem_wdata,
	output wire                        mem_wr,
	output wire                        mem_rd
);
	import cart_pkg::*;

	logic      rom_active;
	logic      cart_mode;
	rom_mask_t rom_mask;
	region_t   header_region;
	logic      rom_rd_stb;
	cpu_addr_t rom_word_addr;

	////////////////////////////////////////////////////////////////////////////
	// Input side
	cart_load_tracker u_load_tracker (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.load_active   (load_active),
		.load_index    (load_index),
		.load_wr       (load_wr),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.rom_active    (rom_active),
		.cart_mode     (cart_mode),
		.rom_mask      (rom_mask),
		.header_region (header_region)
	);

	region_select #(
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) u_region_select (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.header_region (header_region),
		.region_ovr    (region_ovr),
		.region        (region),
		.pal           (pal),
		.region_settle (region_settle)
	);

	////////////////////////////////////////////////////////////////////////////
	// Mapper and memory port
	bank_mapper u_bank_mapper (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.rom_active    (rom_active),
		.rom_mask      (rom_mask),
		.page_wr       (page_wr),
		.page_sel      (page_sel),
		.page_data     (page_data),
		.cpu_rd        (cpu_rd),
		.cpu_addr      (cpu_addr),
		.rom_rd_stb    (rom_rd_stb),
		.rom_word_addr (rom_word_addr)
	);

	mem_request u_mem_request (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.rom_active    (rom_active),
		.cart_mode     (cart_mode),
		.load_wr       (load_wr),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.rom_rd_stb    (rom_rd_stb),
		.rom_word_addr (rom_word_addr),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_wr        (mem_wr),
		.mem_rd        (mem_rd)
	);

endmodule

`default_nettype wire

// File: dv/cart_top_tb.sv
// Table-driven testbench for the cartridge loader top level; compile with the file list and run
`timescale 1ns/1ps
`default_nettype none

module cart_top_tb;
	import cart_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int SETTLE     = 12;
	localparam int NUM_STEPS  = 31;

	typedef enum logic [2:0] {K_LOAD, K_PAGE, K_READ, K_IDLE, K_REGION} kind_t;

	typedef struct packed {
		kind_t       kind;
		logic        active;     // load_active level during the step
		logic [7:0]  index;
		load_addr_t  addr;       // Load address, page select or CPU address
		word_t       data;       // Zero means a random word
		region_ovr_t ovr;
		region_t     exp_region;
	} step_t;

	logic        clk_sys;
	logic        reset;
	logic        load_active;
	logic [7:0]  load_index;
	logic        load_wr;
	load_addr_t  load_addr;
	word_t       load_data;
	logic        page_wr;
	page_sel_t   page_sel;
	bank_t       page_data;
	logic        cpu_rd;
	cpu_addr_t   cpu_addr;
	region_ovr_t region_ovr;
	region_t     region;
	logic        pal;
	logic        region_settle;
	mem_addr_t   mem_addr;
	word_t       mem_wdata;
	logic        mem_wr;
	logic        mem_rd;

	step_t       steps [NUM_STEPS];
	int          errors;

	// Reference model state
	rom_mask_t   m_mask;
	bank_t       m_bank [NUM_BANKS];
	region_t     m_region;

	cart_top #(
		.SETTLE_CYCLES (SETTLE)
	) u_cart_top (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.load_active   (load_active),
		.load_index    (load_index),
		.load_wr       (load_wr),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.page_wr       (page_wr),
		.page_sel      (page_sel),
		.page_data     (page_data),
		.cpu_rd        (cpu_rd),
		.cpu_addr      (cpu_addr),
		.region_ovr    (region_ovr),
		.region        (region),
		.pal           (pal),
		.region_settle (region_settle),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_wr        (mem_wr),
		.mem_rd        (mem_rd)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	task automatic check_mem(input mem_addr_t got_a, input mem_addr_t exp_a,
		input word_t got_d, input word_t exp_d, input bit with_data);
		if (got_a !== exp_a) begin
			errors++;
			$display("Error at %0t: mem_addr got %h expected %h", $time, got_a, exp_a);
		end
		if (with_data && got_d !== exp_d) begin
			errors++;
			$display("Error at %0t: mem_wdata got %h expected %h", $time, got_d, exp_d);
		end
	endtask

	task automatic check_region(input region_t got, input region_t exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: region got %s expected %s", $time, got.name(), exp.name());
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// Counts the high cycles of region_settle from the next falling edge on
	task automatic measure_settle(input string why);
		int wait_n = 0;
		int high_n = 0;
		@(negedge clk_sys);
		while (!region_settle && wait_n < 4) begin
			wait_n++;
			@(negedge clk_sys);
		end
		if (!region_settle) begin
			errors++;
			$display("Settle window never opened after %s at %0t", why, $time);
		end else begin
			while (region_settle && high_n < 4 * SETTLE) begin
				high_n++;
				@(negedge clk_sys);
			end
			if (high_n != SETTLE) begin
				errors++;
				$display("Error at %0t: region_settle cycles got %0d expected %0d",
					$time, high_n, SETTLE);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	function automatic mem_addr_t load_target(input load_addr_t a, input logic cart);
		if (cart) return {2'b00, a[22:1]};
		return BIOS_BASE + {6'd0, a[18:1]};
	endfunction

	function automatic mem_addr_t read_target(input cpu_addr_t a);
		cpu_addr_t full;
		full = {m_bank[a[20:18]], a[17:0]}; // Window bits pick the bank
		full = full & {m_mask, 12'hFFF};
		return {2'b00, full[21:0]};
	endfunction

	function automatic step_t make_step(input kind_t k, input logic act, input logic [7:0] idx,
		input load_addr_t a, input word_t d, input region_ovr_t o, input region_t r);
		step_t s;
		s = '{k, act, idx, a, d, o, r};
		return s;
	endfunction

	task automatic fill_table();
		steps[0]  = make_step(K_LOAD,   1'b1, 8'h00, 25'h000010, 16'h0,    AUTO,     JP);
		steps[1]  = make_step(K_LOAD,   1'b1, 8'h00, 25'h03FFFE, 16'h0,    AUTO,     JP);
		steps[2]  = make_step(K_LOAD,   1'b1, 8'h40, 25'h000000, 16'h0,    AUTO,     JP);
		steps[3]  = make_step(K_LOAD,   1'b1, 8'h40, 25'h0001F0, 16'h0055, AUTO,     JP);
		steps[4]  = make_step(K_REGION, 1'b1, 8'h40, 25'h0,      16'h0,    AUTO,     US);
		steps[5]  = make_step(K_LOAD,   1'b1, 8'h40, 25'h0FFFFE, 16'h0,    AUTO,     US);
		steps[6]  = make_step(K_IDLE,   1'b0, 8'h40, 25'h0,      16'h0,    AUTO,     US);
		steps[7]  = make_step(K_PAGE,   1'b0, 8'h40, 25'h2,      16'h3,    AUTO,     US);
		steps[8]  = make_step(K_READ,   1'b0, 8'h40, 25'h0A1234, 16'h0,    AUTO,     US);
		steps[9]  = make_step(K_READ,   1'b0, 8'h40, 25'h7C0011, 16'h0,    AUTO,     US);
		steps[10] = make_step(K_REGION, 1'b0, 8'h40, 25'h0,      16'h0,    FORCE_EU, EU);
		steps[11] = make_step(K_REGION, 1'b0, 8'h40, 25'h0,      16'h0,    FORCE_JP, JP);
		steps[12] = make_step(K_REGION, 1'b0, 8'h40, 25'h0,      16'h0,    AUTO,     US);
		steps[13] = make_step(K_LOAD,   1'b1, 8'h40, 25'h000000, 16'h0,    AUTO,     US);
		steps[14] = make_step(K_LOAD,   1'b1, 8'h40, 25'h4FFFFE, 16'h0,    AUTO,     US);
		steps[15] = make_step(K_LOAD,   1'b1, 8'h40, 25'h0001F0, 16'h0045, AUTO,     US);
		steps[16] = make_step(K_REGION, 1'b1, 8'h40, 25'h0,      16'h0,    AUTO,     EU);
		steps[17] = make_step(K_IDLE,   1'b0, 8'h40, 25'h0,      16'h0,    AUTO,     EU);
		steps[18] = make_step(K_PAGE,   1'b0, 8'h40, 25'h1,      16'h8,    AUTO,     EU);
		steps[19] = make_step(K_PAGE,   1'b0, 8'h40, 25'h7,      16'h9,    AUTO,     EU);
		steps[20] = make_step(K_PAGE,   1'b0, 8'h40, 25'h0,      16'h3,    AUTO,     EU);
		steps[21] = make_step(K_READ,   1'b0, 8'h40, 25'h040100, 16'h0,    AUTO,     EU);
		steps[22] = make_step(K_READ,   1'b0, 8'h40, 25'h1C0004, 16'h0,    AUTO,     EU);
		steps[23] = make_step(K_READ,   1'b0, 8'h40, 25'h000020, 16'h0,    AUTO,     EU);
		steps[24] = make_step(K_LOAD,   1'b1, 8'h40, 25'h000002, 16'h0,    AUTO,     EU);
		steps[25] = make_step(K_READ,   1'b1, 8'h40, 25'h040100, 16'h0,    AUTO,     EU);
		steps[26] = make_step(K_IDLE,   1'b0, 8'h40, 25'h0,      16'h0,    AUTO,     EU);
		steps[27] = make_step(K_READ,   1'b0, 8'h40, 25'h040100, 16'h0,    AUTO,     EU);
		steps[28] = make_step(K_REGION, 1'b0, 8'h40, 25'h0,      16'h0,    FORCE_EU, EU);
		steps[29] = make_step(K_LOAD,   1'b1, 8'h40, 25'h0001F0, 16'h004A, FORCE_EU, EU);
		steps[30] = make_step(K_REGION, 1'b0, 8'h40, 25'h0,      16'h0,    AUTO,     JP);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Step driver
	task automatic run_step(input step_t s);
		logic      rom_act;
		word_t     d;
		mem_addr_t exp_a;
		rom_act = s.active && (s.index[5:0] <= 6'd1);
		d = (s.data == '0) ? word_t'($urandom) : s.data;
		exp_a = '0;
		@(posedge clk_sys);
		load_active <= s.active;
		load_index  <= s.index;
		case (s.kind)
			K_LOAD: begin
				load_wr   <= 1'b1;
				load_addr <= s.addr;
				load_data <= d;
			end
			K_PAGE: begin
				page_wr   <= 1'b1;
				page_sel  <= s.addr[2:0];
				page_data <= s.data[4:0];
			end
			K_READ: begin
				cpu_rd   <= 1'b1;
				cpu_addr <= s.addr[22:0];
			end
			K_REGION: region_ovr <= s.ovr;
			default: ;
		endcase

		if (s.kind == K_REGION) begin
			if (s.exp_region != m_region) begin
				measure_settle("region change");
			end else begin
				repeat (3) begin
					@(negedge clk_sys);
					check_flag("region_settle", region_settle, 1'b0);
				end
			end
			m_region = s.exp_region;
			check_region(region, s.exp_region);
			check_flag("pal", pal, s.exp_region == EU);
			return;
		end

		if (s.kind == K_READ && !rom_act) exp_a = read_target(s.addr[22:0]);
		@(posedge clk_sys);
		load_wr <= 1'b0;
		page_wr <= 1'b0;
		cpu_rd  <= 1'b0;
		@(negedge clk_sys);
		check_flag("mem_wr", mem_wr, s.kind == K_LOAD && rom_act);
		check_flag("mem_rd", mem_rd, s.kind == K_READ && !rom_act);
		if (s.kind == K_LOAD) begin
			check_mem(mem_addr, load_target(s.addr, s.index[6]),
				mem_wdata, {d[7:0], d[15:8]}, 1'b1);
			if (s.index[6]) begin
				m_mask = (s.addr == '0) ? '0 : (m_mask | s.addr[23:13]);
			end
		end else if (s.kind == K_READ && !rom_act) begin
			check_mem(mem_addr, exp_a, mem_wdata, '0, 1'b0);
		end else if (s.kind == K_PAGE) begin
			if ((m_mask[10] || m_mask[9]) && s.addr[2:0] != 3'd0) begin
				m_bank[s.addr[2:0]] = s.data[4:0];
			end
		end
		if (rom_act) begin
			for (int i = 0; i < NUM_BANKS; i++) m_bank[i] = bank_t'(i);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	initial begin
		errors      = 0;
		void'($urandom(45379));
		reset       = 1'b1;
		load_active = 1'b0;
		load_index  = '0;
		load_wr     = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		page_wr     = 1'b0;
		page_sel    = '0;
		page_data   = '0;
		cpu_rd      = 1'b0;
		cpu_addr    = '0;
		region_ovr  = AUTO;
		m_mask      = '0;
		m_region    = JP;
		for (int i = 0; i < NUM_BANKS; i++) m_bank[i] = bank_t'(i);
		fill_table();

		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		measure_settle("reset"); // Window opens during reset
		check_region(region, JP);

		for (int i = 0; i < NUM_STEPS; i++) begin
			run_step(steps[i]);
		end

		$display("Checks done with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#((NUM_STEPS * 20 + SETTLE) * CLK_PERIOD);
		$display("Timeout, the step table did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: cart_top.f
logic/cart_pkg.sv
logic/cart_load_tracker.sv
logic/region_select.sv
logic/bank_mapper.sv
logic/mem_request.sv
logic/cart_top.sv
dv/cart_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f cart_top.f --top-module cart_top_tb \
	-Mdir obj_dir -o cart_top_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/cart_top_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^TEST PASSED$"; then
	exit 0
else
	exit 1
fi
